// ==== bench/loader_tb.sv ====
// Loader testbench covering download mapping, PROM writes, board variant, slot fetch and clock enables
`timescale 1ns/1ns
`include "loader_cfg.svh"

module loader_tb;

    localparam int TBL_N           = 14;
    localparam int FETCH_N         = 6;
    localparam int WATCHDOG_CYCLES = 200 * TBL_N + 2000;

    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
    } byte_entry_t;

    logic                   clk;
    logic                   rst;
    logic                   downloading;
    logic [24:0]            ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   ioctl_wr;
    loader_pkg::prog_word_t prog;
    logic                   prog_we;
    logic                   prom_we;
    logic [10:0]            prom_addr;
    logic [7:0]             prom_data;
    logic                   alt_board;
    loader_pkg::sdram_rd_t  sdram_bus;
    logic                   sdram_ack;
    logic                   data_dst;
    logic                   data_rdy;
    logic [15:0]            data_read;
    logic                   slot_cs;
    logic [`SLOT_AW-1:0]    slot_addr;
    loader_pkg::slot_rsp_t  slot;
    logic                   pxl2_cen;
    logic                   pxl_cen;
    byte_entry_t            tbl [TBL_N];
    logic                   exp_alt;
    string                  phase;

    game_loader_top UUT (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog        (prog),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data),
        .alt_board   (alt_board),
        .sdram       (sdram_bus),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .slot_cs     (slot_cs),
        .slot_addr   (slot_addr),
        .slot        (slot),
        .pxl2_cen    (pxl2_cen),
        .pxl_cen     (pxl_cen)
    );

    // Writes and reads share the one acknowledge
    sdram_stub sdram_model (
        .clk       (clk),
        .rst       (rst),
        .req       (sdram_bus.req | prog_we),
        .rd        (sdram_bus.req),
        .addr      (sdram_bus.addr),
        .ack       (sdram_ack),
        .data_dst  (data_dst),
        .data_rdy  (data_rdy),
        .data_read (data_read)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h actual %h", phase, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Code, scroll, object, PCM, then PROM bytes
    task automatic fill_table();
        tbl[0]  = {22'h00_0100, 8'hA5};
        tbl[1]  = {22'h00_0101, 8'h3C};
        tbl[2]  = {`SCR_START, 8'h11};
        tbl[3]  = {`SCR_START + 22'h1B, 8'h22};
        tbl[4]  = {`SCR_START + 22'h16, 8'h33};
        tbl[5]  = {`OBJ_START, 8'h44};
        tbl[6]  = {`OBJ_START + 22'h3D, 8'h55};
        tbl[7]  = {`OBJ_START + 22'h2E, 8'h66};
        tbl[8]  = {`PCM_START + 22'h1234, 8'h77};
        tbl[9]  = {`PROM_START - 22'd1, 8'h88};
        tbl[10] = {`PROM_START, 8'h12};
        tbl[11] = {`PROM_START + 22'd1, 8'hFF};
        tbl[12] = {`PROM_START + 22'h7FF, 8'h9C};
        tbl[13] = {`PROM_START + 22'd1, 8'h3C};
    endtask

    // Word address with the tile bit reorder of each region
    function automatic logic [21:0] expected_word(input logic [21:0] a);
        logic [21:0] w;
        w = {1'b0, a[21:1]};
        if (a >= `PCM_START) begin
            w = {1'b0, a[21:1]};
        end else if (a >= `OBJ_START) begin
            w[4:0] = {w[2], w[1], w[0], ~w[4], ~w[3]};
        end else if (a >= `SCR_START) begin
            w[3:0] = {w[2], w[1], w[0], ~w[3]};
        end
        return w;
    endfunction

    task automatic write_byte(input byte_entry_t e);
        logic [21:0] prom_off;
        prom_off   = e.addr - `PROM_START;
        ioctl_addr = {3'b000, e.addr};
        ioctl_dout = e.data;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        if (e.addr >= `PROM_START) begin
            if (e.addr == `PROM_START + 22'd1) begin
                exp_alt = &e.data;
            end
            check("prom_we pulse", 1, prom_we);
            check("prom addr", prom_off[10:0], prom_addr);
            check("prom data", e.data, prom_data);
            check("prog_we on prom", 0, prog_we);
            check("alt_board", exp_alt, alt_board);
            next_cycle();
            check("prom_we width", 0, prom_we);
            check("prog_we after prom", 0, prog_we);
        end else begin
            check("prog_we rise", 1, prog_we);
            check("prog addr", expected_word(e.addr), prog.addr);
            check("prog data", e.data, prog.data);
            check("prog mask", e.addr[0] ? 2'b01 : 2'b10, prog.mask);
            while (!sdram_ack) begin
                next_cycle();
                check("prog_we held", 1, prog_we);
            end
            next_cycle();
            check("prog_we fall", 0, prog_we);
        end
    endtask

    task automatic fetch_word(input logic [`SLOT_AW-1:0] a, input logic expect_req);
        logic        req_seen;
        logic [21:0] slot_word;
        logic [21:0] exp_addr;
        logic [21:0] lo_full;
        logic [21:0] hi_full;
        logic [31:0] exp_data;
        req_seen  = 1'b0;
        slot_word = {{(22 - `SLOT_AW){1'b0}}, a};
        exp_addr  = `SCR_START / 22'd2 + slot_word * 22'd2;
        lo_full   = exp_addr * 22'd3;
        hi_full   = exp_addr * 22'd3 + 22'd1;
        exp_data  = {hi_full[15:0] ^ 16'h5a5a, lo_full[15:0] ^ 16'h5a5a};
        slot_addr = a;
        slot_cs   = 1'b1;
        #1;
        if (expect_req) begin
            check("miss before fetch", 0, slot.ok);
        end
        while (!slot.ok) begin
            next_cycle();
            if (sdram_bus.req) begin
                req_seen = 1'b1;
                check("sdram addr", exp_addr, sdram_bus.addr);
            end
        end
        check("sdram request", expect_req, req_seen);
        check("slot data", exp_data, slot.data);
    endtask

    initial begin
        int unsigned         rnd;
        int                  pxl2_cnt;
        int                  pxl_cnt;
        logic [`SLOT_AW-1:0] addr_pick;
        logic [`SLOT_AW-1:0] last_addr;
        rnd         = $urandom(24497);
        rst         = 1'b1;
        downloading = 1'b1;
        ioctl_addr  = 25'd0;
        ioctl_dout  = 8'd0;
        ioctl_wr    = 1'b0;
        slot_cs     = 1'b0;
        slot_addr   = '0;
        exp_alt     = 1'b0;
        pxl2_cnt    = 0;
        pxl_cnt     = 0;
        last_addr   = '0;
        phase       = "reset";
        fill_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check("prog_we", 0, prog_we);
        check("prom_we", 0, prom_we);
        check("sdram req", 0, sdram_bus.req);
        check("slot ok", 0, slot.ok);
        check("alt_board", 0, alt_board);
        check("pxl2_cen", 0, pxl2_cen);
        check("pxl_cen", 0, pxl_cen);

        phase = "clock enables";
        repeat (64) begin
            check("pxl_cen without pxl2_cen", 1, !pxl_cen || pxl2_cen);
            pxl2_cnt += pxl2_cen;
            pxl_cnt  += pxl_cen;
            next_cycle();
        end
        check("pxl2_cen count", 16, pxl2_cnt);
        check("pxl_cen count", 8, pxl_cnt);

        phase = "download";
        for (int i = 0; i < TBL_N; i++) begin
            write_byte(tbl[i]);
            next_cycle();
        end

        phase = "fetch";
        downloading = 1'b0;
        next_cycle();
        for (int i = 0; i < FETCH_N; i++) begin
            rnd       = $urandom;
            addr_pick = rnd[`SLOT_AW-1:0];
            fetch_word(addr_pick, i == 0 || addr_pick != last_addr);
            last_addr = addr_pick;
            slot_cs   = 1'b0;
            next_cycle();
        end

        // Same word again is served from the buffer
        phase = "hit";
        fetch_word(last_addr, 1'b0);
        repeat (4) begin
            next_cycle();
            check("no sdram req on hit", 0, sdram_bus.req);
            check("ok held on hit", 1, slot.ok);
        end

        phase = "invalidate";
        downloading = 1'b1;
        #1;
        check("ok during download", 0, slot.ok);
        repeat (3) begin
            next_cycle();
            check("ok during download", 0, slot.ok);
            check("no req during download", 0, sdram_bus.req);
        end
        downloading = 1'b0;
        fetch_word(last_addr, 1'b1);
        slot_cs = 1'b0;
        next_cycle();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== bench/sdram_stub.sv ====
// SDRAM read model: acknowledges requests and returns halfwords derived from the address
`timescale 1ns/1ns

module sdram_stub (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        rd,
    input  logic [21:0] addr,
    output logic        ack,
    output logic        data_dst,
    output logic        data_rdy,
    output logic [15:0] data_read
);

    logic        busy;
    logic        is_read;
    logic [2:0]  cnt;
    logic [21:0] word_addr;

    // Memory contents as a fixed function of the word address
    function automatic logic [15:0] half_value(input logic [21:0] a, input logic k);
        logic [21:0] v;
        v = a * 22'd3 + {21'd0, k};
        return v[15:0] ^ 16'h5a5a;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            is_read   <= 1'b0;
            cnt       <= 3'd0;
            word_addr <= 22'd0;
            ack       <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= 16'd0;
        end else begin
            ack      <= 1'b0;
            data_dst <= 1'b0;
            data_rdy <= 1'b0;
            if (!busy) begin
                if (req) begin
                    busy      <= 1'b1;
                    is_read   <= rd;
                    cnt       <= 3'd0;
                    word_addr <= addr;
                end
            end else begin
                cnt <= cnt + 3'd1;
                case (cnt)
                    3'd0: begin
                        ack <= 1'b1;
                    end
                    3'd1: begin
                        // Writes end with the acknowledge
                        if (is_read) begin
                            data_dst  <= 1'b1;
                            data_read <= half_value(word_addr, 1'b0);
                        end else begin
                            busy <= 1'b0;
                        end
                    end
                    3'd4: begin
                        data_dst  <= 1'b1;
                        data_rdy  <= 1'b1;
                        data_read <= half_value(word_addr, 1'b1);
                        busy      <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/dwnld_mapper.sv ====
// Download mapper: sorts ioctl bytes into regions, reorders tile addresses, drives SDRAM and PROM writes
`timescale 1ns/1ns
`include "loader_cfg.svh"

module dwnld_mapper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   downloading,
    input  logic                   ioctl_wr,
    input  logic                   sdram_ack,
    input  logic [24:0]            ioctl_addr,
    input  logic [7:0]             ioctl_dout,
    output loader_pkg::prog_word_t prog,
    output logic                   prog_we,
    output logic                   prom_we,
    output logic                   alt_board,
    output logic [10:0]            prom_addr,
    output logic [7:0]             prom_data
);

    localparam logic [21:0] SCR_START  = `SCR_START;
    localparam logic [21:0] OBJ_START  = `OBJ_START;
    localparam logic [21:0] PCM_START  = `PCM_START;
    localparam logic [21:0] PROM_START = `PROM_START;

    logic [21:0]          byte_addr;
    logic [21:0]          prom_off;
    logic                 wr_en;
    logic                 prog_wr;
    logic                 prom_wr;
    loader_pkg::region_e  region;
    loader_pkg::dl_addr_u word_addr;
    loader_pkg::dl_addr_u mapped_addr;

    assign byte_addr = ioctl_addr[21:0];
    assign wr_en     = ioctl_wr && downloading;
    assign prom_off  = byte_addr - PROM_START;

    // Region decode, highest region first
    always_comb begin
        if (byte_addr >= PROM_START) begin
            region = loader_pkg::REG_PROM;
        end else if (byte_addr >= PCM_START) begin
            region = loader_pkg::REG_PCM;
        end else if (byte_addr >= OBJ_START) begin
            region = loader_pkg::REG_OBJ;
        end else if (byte_addr >= SCR_START) begin
            region = loader_pkg::REG_SCR;
        end else begin
            region = loader_pkg::REG_CODE;
        end
    end

    assign prog_wr = wr_en && region != loader_pkg::REG_PROM;
    assign prom_wr = wr_en && region == loader_pkg::REG_PROM;

    // Tile data is stored so that one 32-bit read holds a full pixel row
    always_comb begin
        word_addr.raw = {1'b0, byte_addr[21:1]};
        mapped_addr   = word_addr;
        case (region)
            loader_pkg::REG_SCR: begin
                mapped_addr.tile.lo[3:0] = {word_addr.tile.lo[2:0], ~word_addr.tile.lo[3]};
            end
            loader_pkg::REG_OBJ: begin
                mapped_addr.tile.lo = {word_addr.tile.lo[2:0],
                                       ~word_addr.tile.lo[4],
                                       ~word_addr.tile.lo[3]};
            end
            default: begin
                mapped_addr = word_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we   <= 1'b0;
            prom_we   <= 1'b0;
            alt_board <= 1'b0;
        end else begin
            prom_we <= prom_wr;
            // Held until the SDRAM takes the byte
            if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (prog_wr) begin
                prog_we <= 1'b1;
            end
            // Second PROM byte flags the alternate board
            if (wr_en && byte_addr == PROM_START + 22'd1) begin
                alt_board <= &ioctl_dout;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_wr) begin
            prog.addr <= mapped_addr.raw;
            prog.data <= ioctl_dout;
            prog.mask <= byte_addr[0] ? 2'b01 : 2'b10;
        end
        if (prom_wr) begin
            prom_addr <= prom_off[10:0];
            prom_data <= ioctl_dout;
        end
    end

    // Host must wait for the SDRAM write to finish
    property p_no_overlap;
        @(posedge clk) disable iff (rst)
        prog_we |-> !(ioctl_wr && downloading);
    endproperty

    a_no_overlap: assert property (p_no_overlap)
        else $error("ioctl write while SDRAM write pending");

endmodule

// ==== design/game_loader_top.sv ====
// Game loader top: ROM download mapping, scroll slot fetch and pixel clock enables
`timescale 1ns/1ns
`include "loader_cfg.svh"

module game_loader_top (
    input  logic                   clk,
    input  logic                   rst,
    // ioctl download
    input  logic                   downloading,
    input  logic [24:0]            ioctl_addr,
    input  logic [7:0]             ioctl_dout,
    input  logic                   ioctl_wr,
    output loader_pkg::prog_word_t prog,
    output logic                   prog_we,
    output logic                   prom_we,
    output logic [10:0]            prom_addr,
    output logic [7:0]             prom_data,
    output logic                   alt_board,
    // SDRAM read port
    output loader_pkg::sdram_rd_t  sdram,
    input  logic                   sdram_ack,
    input  logic                   data_dst,
    input  logic                   data_rdy,
    input  logic [15:0]            data_read,
    // Scroll slot
    input  logic                   slot_cs,
    input  logic [`SLOT_AW-1:0]    slot_addr,
    output loader_pkg::slot_rsp_t  slot,
    // Pixel enables
    output logic                   pxl2_cen,
    output logic                   pxl_cen
);

    logic miss;
    logic half_sel;
    logic half_we;
    logic fill_done;

    pixel_cen_gen u_cen (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    dwnld_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .prog        (prog),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .alt_board   (alt_board),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data)
    );

    rom_fetch_fsm u_fetch (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .miss        (miss),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .slot_addr   (slot_addr),
        .sdram       (sdram),
        .half_sel    (half_sel),
        .half_we     (half_we),
        .fill_done   (fill_done)
    );

    rom_slot_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .slot_cs     (slot_cs),
        .half_sel    (half_sel),
        .half_we     (half_we),
        .fill_done   (fill_done),
        .slot_addr   (slot_addr),
        .data_read   (data_read),
        .miss        (miss),
        .slot        (slot)
    );

endmodule

// ==== design/loader_pkg.sv ====
// Loader package: download region codes, SDRAM bus structs and the download address union
package loader_pkg;

    // Download region of the current byte
    typedef enum logic [2:0] {
        REG_CODE,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM
    } region_e;

    // One SDRAM byte write, mask is active low
    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;
    } prog_word_t;

    // Tile view of a word address, only lo gets reordered
    typedef struct packed {
        logic [16:0] hi;
        logic [4:0]  lo;
    } tile_addr_t;

    typedef union packed {
        logic [21:0] raw;
        tile_addr_t  tile;
    } dl_addr_u;

    // Read request towards the SDRAM controller
    typedef struct packed {
        logic        req;
        logic [21:0] addr;
    } sdram_rd_t;

    // Slot response back to the graphics side
    typedef struct packed {
        logic [31:0] data;
        logic        ok;
    } slot_rsp_t;

endpackage

// ==== design/pixel_cen_gen.sv ====
// Pixel clock enable generator: 12 MHz and 6 MHz strobes derived from the 48 MHz clock
`timescale 1ns/1ns

module pixel_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= 3'd0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // One pulse every 4 cycles, and every 8 cycles for the slower one
    assign pxl2_cen = cnt[1:0] == 2'd3;
    assign pxl_cen  = &cnt;

    // 6 MHz enable lands on a 12 MHz one and repeats every 8 cycles
    property p_pxl_aligned;
        @(posedge clk) disable iff (rst)
        pxl_cen |-> pxl2_cen ##8 pxl_cen;
    endproperty

    a_pxl_aligned: assert property (p_pxl_aligned)
        else $error("pxl_cen out of step with pxl2_cen");

endmodule

// ==== design/rom_fetch_fsm.sv ====
// Scroll slot fetch FSM: turns a slot miss into one two-halfword SDRAM read burst
`timescale 1ns/1ns
`include "loader_cfg.svh"

module rom_fetch_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  downloading,
    input  logic                  miss,
    input  logic                  sdram_ack,
    input  logic                  data_dst,
    input  logic                  data_rdy,
    input  logic [`SLOT_AW-1:0]   slot_addr,
    output loader_pkg::sdram_rd_t sdram,
    output logic                  half_sel,
    output logic                  half_we,
    output logic                  fill_done
);

    // Scroll region offset in SDRAM words
    localparam logic [21:0] SCR_WORD = `SCR_START >> 1;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_e;

    state_e      state;
    logic        half_cnt;
    logic        start;
    logic [21:0] fetch_addr;
    logic [21:0] req_addr;

    // Each 32-bit slot word spans two SDRAM words
    assign fetch_addr = SCR_WORD + {{(21 - `SLOT_AW){1'b0}}, slot_addr, 1'b0};
    assign start      = state == IDLE && miss && !downloading;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            half_cnt <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin
                        state    <= WAIT;
                        half_cnt <= 1'b0;
                    end
                end
                WAIT: begin
                    if (data_dst) begin
                        half_cnt <= ~half_cnt;
                    end
                    // Last halfword and ready arrive together
                    if (data_rdy) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address frozen for the whole burst
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= fetch_addr;
        end
    end

    assign sdram.req  = state == REQ;
    assign sdram.addr = req_addr;
    assign half_sel   = half_cnt;
    assign half_we    = state == WAIT && data_dst;
    assign fill_done  = state == WAIT && data_rdy;

    // Request is only withdrawn once the controller has taken it
    property p_req_held;
        @(posedge clk) disable iff (rst)
        sdram.req && !sdram_ack |=> sdram.req;
    endproperty

    a_req_held: assert property (p_req_held)
        else $error("sdram req dropped before ack");

endmodule

// ==== design/rom_slot_buffer.sv ====
// Scroll slot buffer: caches one 32-bit ROM word with its address and reports hit or miss
`timescale 1ns/1ns
`include "loader_cfg.svh"

module rom_slot_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  downloading,
    input  logic                  slot_cs,
    input  logic                  half_sel,
    input  logic                  half_we,
    input  logic                  fill_done,
    input  logic [`SLOT_AW-1:0]   slot_addr,
    input  logic [15:0]           data_read,
    output logic                  miss,
    output loader_pkg::slot_rsp_t slot
);

    logic                valid;
    logic                filling;
    logic                fill_start;
    logic                hit;
    logic [`SLOT_AW-1:0] tag;
    logic [`SLOT_AW-1:0] fill_tag;
    logic [31:0]         word;

    // SDRAM contents may change while a download runs
    assign hit  = slot_cs && valid && !downloading && tag == slot_addr;
    assign miss = slot_cs && !hit;

    // Same condition that moves the fetch FSM out of IDLE
    assign fill_start = miss && !downloading && !filling;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= 1'b0;
            filling <= 1'b0;
        end else begin
            if (fill_start) begin
                filling <= 1'b1;
            end
            if (fill_done) begin
                filling <= 1'b0;
            end
            if (downloading) begin
                valid <= 1'b0;
            end else if (fill_done) begin
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            fill_tag <= slot_addr;
        end
        if (fill_done) begin
            tag <= fill_tag;
        end
        // Low half arrives first
        if (half_we) begin
            if (half_sel) begin
                word[31:16] <= data_read;
            end else begin
                word[15:0] <= data_read;
            end
        end
    end

    assign slot.data = word;
    assign slot.ok   = hit;

endmodule

// ==== files.f ====
+incdir+include
design/loader_pkg.sv
design/pixel_cen_gen.sv
design/dwnld_mapper.sv
design/rom_fetch_fsm.sv
design/rom_slot_buffer.sv
design/game_loader_top.sv
bench/sdram_stub.sv
bench/loader_tb.sv

// ==== include/loader_cfg.svh ====
// Loader configuration: download region boundaries and scroll slot geometry
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// Byte addresses in the 22-bit download space
// Code occupies everything below the scroll tiles
`define SCR_START   (22'h01_0000)
`define OBJ_START   (22'h02_0000)
`define PCM_START   (22'h03_0000)

// Colour and lookup PROMs come last
`define PROM_START  (22'h03_8000)

// Scroll slot reads 32-bit words
`define SLOT_AW     14

`endif
